// File: timer_pkg.sv
package timer_pkg;

    // ******************************************************************
    // Widths
    // ******************************************************************
    localparam int DATA_W  = 8;   // Register bus width
    localparam int PRESC_W = 16;
    localparam int CNT_W   = 8;
    localparam int MODE_W  = 2;
    localparam int FLAG_W  = 3;   // top, match0, match1

    // Default bus base address
    localparam logic [DATA_W-1:0] TIMER_BASE_ADDR = 8'h00;

    // ******************************************************************
    // Register offsets from the base address
    // ******************************************************************
    localparam logic [DATA_W-1:0] OFS_SCALE_LO = 8'd0;
    localparam logic [DATA_W-1:0] OFS_SCALE_HI = 8'd1;
    localparam logic [DATA_W-1:0] OFS_CONTROL  = 8'd2;
    localparam logic [DATA_W-1:0] OFS_CMPR0    = 8'd3;
    localparam logic [DATA_W-1:0] OFS_CMPR1    = 8'd4;
    localparam logic [DATA_W-1:0] OFS_COUNTER  = 8'd5;   // Read only
    localparam logic [DATA_W-1:0] OFS_FLAGS    = 8'd6;   // Last offset in range

    typedef enum logic [MODE_W-1:0] {
        MODE_IDLE = 2'b00,
        MODE_CTC  = 2'b01,
        MODE_PWM  = 2'b10,
        MODE_HOLD = 2'b11
    } mode_t;

    // Control byte layout
    localparam int CTRL_MODE_LSB = 0;   // Mode in bits 1:0
    localparam int CTRL_TOP_IE   = 4;
    localparam int CTRL_M0_IE    = 5;
    localparam int CTRL_M1_IE    = 6;

    // Flag register layout
    localparam int FLAG_TOP = 0;
    localparam int FLAG_M0  = 1;
    localparam int FLAG_M1  = 2;

endpackage

// File: timer_cfg_if.sv
`timescale 1ns/1ps

interface timer_cfg_if;
    import timer_pkg::*;

    logic [PRESC_W-1:0] scale_factor;
    mode_t              mode;
    logic [CNT_W-1:0]   cmpr0;
    logic [CNT_W-1:0]   cmpr1;
    logic               top_ie;    // Interrupt enables
    logic               m0_ie;
    logic               m1_ie;

    // Register block side
    modport regs (
        output scale_factor, mode, cmpr0, cmpr1, top_ie, m0_ie, m1_ie
    );

    // Prescaler, counter and irq side
    modport core (
        input scale_factor, mode, cmpr0, cmpr1, top_ie, m0_ie, m1_ie
    );

endinterface

// File: timer_regs.sv
`timescale 1ns/1ps

module timer_regs #(
    parameter logic [timer_pkg::DATA_W-1:0] BASE_ADDR = timer_pkg::TIMER_BASE_ADDR
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [timer_pkg::DATA_W-1:0] address,
    input  logic [timer_pkg::DATA_W-1:0] din,
    input  logic                         w_en,
    input  logic                         r_en,
    output logic [timer_pkg::DATA_W-1:0] dout,
    input  logic [timer_pkg::FLAG_W-1:0] flags,
    output logic                         flag_wr,
    output logic [timer_pkg::FLAG_W-1:0] flag_wdata,
    input  logic [timer_pkg::CNT_W-1:0]  counter,
    timer_cfg_if.regs                    cfg
);
    import timer_pkg::*;

    logic [DATA_W-1:0]  offset;
    logic               in_range;
    logic               wr_hit;
    logic               rd_hit;

    logic [PRESC_W-1:0] scale_factor;
    logic [DATA_W-1:0]  control;
    logic [CNT_W-1:0]   cmpr0;
    logic [CNT_W-1:0]   cmpr1;
    logic [DATA_W-1:0]  rdata;

    // ******************************************************************
    // Address decode
    // ******************************************************************
    // Addresses below the base wrap to a large offset and fall out of range
    assign offset   = address - BASE_ADDR;
    assign in_range = (offset <= OFS_FLAGS);
    assign wr_hit   = w_en && in_range;
    assign rd_hit   = r_en && in_range;

    // ******************************************************************
    // Configuration registers
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scale_factor <= '0;
            control      <= '0;
            cmpr0        <= '0;
            cmpr1        <= '0;
        end else if (wr_hit) begin
            case (offset)
                OFS_SCALE_LO: scale_factor[7:0]  <= din;
                OFS_SCALE_HI: scale_factor[15:8] <= din;
                OFS_CONTROL:  control            <= din;
                OFS_CMPR0:    cmpr0              <= din;
                OFS_CMPR1:    cmpr1              <= din;
                default: ;                           // Counter is read only, flags live in irq
            endcase
        end
    end

    // Flag register is held in the irq unit, pass the write through
    assign flag_wr    = wr_hit && (offset == OFS_FLAGS);
    assign flag_wdata = din[FLAG_W-1:0];

    // Configuration out to the datapath
    assign cfg.scale_factor = scale_factor;
    assign cfg.mode         = mode_t'(control[CTRL_MODE_LSB +: MODE_W]);
    assign cfg.cmpr0        = cmpr0;
    assign cfg.cmpr1        = cmpr1;
    assign cfg.top_ie       = control[CTRL_TOP_IE];
    assign cfg.m0_ie        = control[CTRL_M0_IE];
    assign cfg.m1_ie        = control[CTRL_M1_IE];

    // ******************************************************************
    // Read mux
    // ******************************************************************
    always_comb begin
        rdata = '0;
        case (offset)
            OFS_SCALE_LO: rdata = scale_factor[7:0];
            OFS_SCALE_HI: rdata = scale_factor[15:8];
            OFS_CONTROL:  rdata = control;
            OFS_CMPR0:    rdata = cmpr0;
            OFS_CMPR1:    rdata = cmpr1;
            OFS_COUNTER:  rdata = counter;
            OFS_FLAGS:    rdata[FLAG_W-1:0] = flags;   // Upper bits read zero
            default:      rdata = '0;
        endcase
    end

    // dout holds until the next read in range
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout <= '0;
        end else if (rd_hit) begin
            dout <= rdata;
        end
    end

endmodule

// File: timer_prescaler.sv
`timescale 1ns/1ps

module timer_prescaler (
    input  logic      clk,
    input  logic      rst_n,
    timer_cfg_if.core cfg,
    output logic      tick
);
    import timer_pkg::*;

    logic [PRESC_W-1:0] presc_cnt;
    logic               wrap;

    // A scale factor of N gives one tick every N+1 clocks.
    // A new factor below the current count only matches after the
    // count rolls over through zero.
    assign wrap = (presc_cnt == cfg.scale_factor);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_cnt <= '0;
            tick      <= 1'b0;
        end else begin
            if (wrap) begin
                presc_cnt <= '0;
                tick      <= 1'b1;   // One cycle pulse
            end else begin
                presc_cnt <= presc_cnt + 1'b1;
                tick      <= 1'b0;
            end
        end
    end

endmodule

// File: timer_counter.sv
`timescale 1ns/1ps

module timer_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    timer_cfg_if.core                   cfg,
    input  logic                        tick,
    output logic [timer_pkg::CNT_W-1:0] counter,
    output logic                        match0,
    output logic                        match1,
    output logic                        top,
    output logic                        pwm0,
    output logic                        pwm1
);
    import timer_pkg::*;

    // ******************************************************************
    // Comparators
    // ******************************************************************
    assign top    = (counter == {CNT_W{1'b1}});
    assign match0 = (counter == cfg.cmpr0);
    assign match1 = (counter == cfg.cmpr1);

    // ******************************************************************
    // Counter and waveform outputs advance on tick only
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counter <= '0;
            pwm0    <= 1'b0;
            pwm1    <= 1'b0;
        end else if (tick) begin
            case (cfg.mode)
                MODE_IDLE: begin
                    counter <= '0;
                    pwm0    <= 1'b0;
                    pwm1    <= 1'b0;
                end

                MODE_CTC: begin
                    if (match0) begin
                        counter <= '0;      // Period is cmpr0 + 1 ticks
                        pwm0    <= ~pwm0;
                    end else begin
                        counter <= counter + 1'b1;
                    end
                end

                MODE_PWM: begin
                    // Outputs rise as the count wraps to zero
                    if (top) begin
                        pwm0 <= 1'b1;
                        pwm1 <= 1'b1;
                    end else begin
                        if (match0) begin
                            pwm0 <= 1'b0;
                        end
                        if (match1) begin
                            pwm1 <= 1'b0;
                        end
                    end
                    counter <= counter + 1'b1;   // Free running and wraps at 255
                end

                MODE_HOLD: begin
                    counter <= counter;     // Frozen while outputs keep their level
                end
            endcase
        end
    end

endmodule

// File: timer_irq.sv
`timescale 1ns/1ps

module timer_irq (
    input  logic                         clk,
    input  logic                         rst_n,
    timer_cfg_if.core                    cfg,
    input  logic                         match0,
    input  logic                         match1,
    input  logic                         top,
    input  logic                         flag_wr,
    input  logic [timer_pkg::FLAG_W-1:0] flag_wdata,
    input  logic                         top_flag_clr,
    input  logic                         match0_flag_clr,
    input  logic                         match1_flag_clr,
    output logic [timer_pkg::FLAG_W-1:0] flags
);
    import timer_pkg::*;

    logic [FLAG_W-1:0] cond;       // Current condition per flag
    logic [FLAG_W-1:0] cond_q;     // Condition one cycle back
    logic [FLAG_W-1:0] cond_rise;
    logic [FLAG_W-1:0] enable;
    logic [FLAG_W-1:0] clr;

    // Gather per flag signals into vectors in flag register order
    assign cond[FLAG_TOP]   = top;
    assign cond[FLAG_M0]    = match0;
    assign cond[FLAG_M1]    = match1;

    assign enable[FLAG_TOP] = cfg.top_ie;
    assign enable[FLAG_M0]  = cfg.m0_ie;
    assign enable[FLAG_M1]  = cfg.m1_ie;

    assign clr[FLAG_TOP]    = top_flag_clr;
    assign clr[FLAG_M0]     = match0_flag_clr;
    assign clr[FLAG_M1]     = match1_flag_clr;

    assign cond_rise = cond & ~cond_q;

    // ******************************************************************
    // Clear beats bus write and bus write beats event
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cond_q <= '0;
            flags  <= '0;
        end else begin
            cond_q <= cond;
            for (int i = 0; i < FLAG_W; i++) begin
                if (clr[i]) begin
                    flags[i] <= 1'b0;
                end else if (flag_wr) begin
                    flags[i] <= flag_wdata[i];
                end else if (cond_rise[i] && enable[i]) begin
                    flags[i] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: timer_top.sv
`timescale 1ns/1ps

module timer_top #(
    parameter logic [timer_pkg::DATA_W-1:0] BASE_ADDR = timer_pkg::TIMER_BASE_ADDR
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [timer_pkg::DATA_W-1:0] address,
    input  logic [timer_pkg::DATA_W-1:0] din,
    input  logic                         w_en,
    input  logic                         r_en,
    output logic [timer_pkg::DATA_W-1:0] dout,
    output logic                         top_flag,
    output logic                         match0_flag,
    output logic                         match1_flag,
    input  logic                         top_flag_clr,
    input  logic                         match0_flag_clr,
    input  logic                         match1_flag_clr,
    output logic                         pwm0,
    output logic                         pwm1
);
    import timer_pkg::*;

    logic              tick;
    logic [CNT_W-1:0]  counter;
    logic              match0;
    logic              match1;
    logic              top;
    logic              flag_wr;
    logic [FLAG_W-1:0] flag_wdata;
    logic [FLAG_W-1:0] flags;

    timer_cfg_if cfg_bus ();   // Register block to datapath

    // ******************************************************************
    // Register block
    // ******************************************************************
    timer_regs #(
        .BASE_ADDR (BASE_ADDR)
    ) u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .din        (din),
        .w_en       (w_en),
        .r_en       (r_en),
        .dout       (dout),
        .flags      (flags),
        .flag_wr    (flag_wr),
        .flag_wdata (flag_wdata),
        .counter    (counter),
        .cfg        (cfg_bus.regs)
    );

    // ******************************************************************
    // Datapath
    // ******************************************************************
    timer_prescaler u_prescaler (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg_bus.core),
        .tick  (tick)
    );

    timer_counter u_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg_bus.core),
        .tick    (tick),
        .counter (counter),
        .match0  (match0),
        .match1  (match1),
        .top     (top),
        .pwm0    (pwm0),
        .pwm1    (pwm1)
    );

    timer_irq u_irq (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg             (cfg_bus.core),
        .match0          (match0),
        .match1          (match1),
        .top             (top),
        .flag_wr         (flag_wr),
        .flag_wdata      (flag_wdata),
        .top_flag_clr    (top_flag_clr),
        .match0_flag_clr (match0_flag_clr),
        .match1_flag_clr (match1_flag_clr),
        .flags           (flags)
    );

    // Flag pins
    assign top_flag    = flags[FLAG_TOP];
    assign match0_flag = flags[FLAG_M0];
    assign match1_flag = flags[FLAG_M1];

endmodule

// File: tb_timer.sv
`timescale 1ns/1ps

module tb_timer;
    import timer_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [7:0]  address;
    logic [7:0]  din;
    logic        w_en;
    logic        r_en;
    logic [7:0]  dout;
    logic        top_flag;
    logic        match0_flag;
    logic        match1_flag;
    logic        top_flag_clr;
    logic        match0_flag_clr;
    logic        match1_flag_clr;
    logic        pwm0;
    logic        pwm1;

    int          mismatches = 0;
    int          failures = 0;
    logic [31:0] lfsr_state = 32'hd882;

    always #4 clk = ~clk;   // 8 ns period

    timer_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .address         (address),
        .din             (din),
        .w_en            (w_en),
        .r_en            (r_en),
        .dout            (dout),
        .top_flag        (top_flag),
        .match0_flag     (match0_flag),
        .match1_flag     (match1_flag),
        .top_flag_clr    (top_flag_clr),
        .match0_flag_clr (match0_flag_clr),
        .match1_flag_clr (match1_flag_clr),
        .pwm0            (pwm0),
        .pwm1            (pwm1)
    );

    // ******************************************************************
    // Clear strobes drop their flag on the next edge
    // ******************************************************************
    assert property (@(posedge clk) disable iff (!rst_n) top_flag_clr |=> !top_flag)
        else begin
            failures++;
            $display("top_flag still high after its clear strobe");
        end
    assert property (@(posedge clk) disable iff (!rst_n) match0_flag_clr |=> !match0_flag)
        else begin
            failures++;
            $display("match0_flag still high after its clear strobe");
        end
    assert property (@(posedge clk) disable iff (!rst_n) match1_flag_clr |=> !match1_flag)
        else begin
            failures++;
            $display("match1_flag still high after its clear strobe");
        end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};   // One step per bit
        end
    endtask

    function automatic logic [7:0] control_byte(input mode_t mode, input logic ie);
        logic [7:0] b;
        b = '0;
        b[CTRL_MODE_LSB +: MODE_W] = mode;
        b[CTRL_TOP_IE] = ie;
        b[CTRL_M0_IE]  = ie;
        b[CTRL_M1_IE]  = ie;
        return b;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            mismatches++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst_n           = 1'b0;
        address         = '0;
        din             = '0;
        w_en            = 1'b0;
        r_en            = 1'b0;
        top_flag_clr    = 1'b0;
        match0_flag_clr = 1'b0;
        match1_flag_clr = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic bus_write(input logic [7:0] ofs, input logic [7:0] data);
        @(posedge clk);
        #1;
        address = TIMER_BASE_ADDR + ofs;
        din     = data;
        w_en    = 1'b1;
        @(posedge clk);
        #1;
        w_en = 1'b0;
    endtask

    // dout is loaded on the edge that ends the r_en cycle
    task automatic bus_read(input logic [7:0] ofs, output logic [7:0] data);
        @(posedge clk);
        #1;
        address = TIMER_BASE_ADDR + ofs;
        r_en    = 1'b1;
        @(posedge clk);
        #1;
        r_en = 1'b0;
        data = dout;
    endtask

    task automatic wait_pwm0(input logic level, input int limit);
        int n;
        n = 0;
        while (pwm0 !== level && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (pwm0 === level) else begin
            failures++;
            $display("timed out waiting for pwm0 to go to %0b", level);
        end
    endtask

    task automatic measure_toggle(input int limit, output int cycles);
        logic start;
        start  = pwm0;
        cycles = 0;
        while (pwm0 === start && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (pwm0 !== start) else begin
            failures++;
            $display("timed out waiting for pwm0 to toggle");
        end
    endtask

    // ******************************************************************
    // Register readback and reset values
    // ******************************************************************
    task automatic regs_test();
        logic [31:0] v;
        logic [7:0]  rd;
        for (int i = 0; i <= 4; i++) begin   // Writable offsets
            rand_bits(8, v);
            bus_write(8'(i), v[7:0]);
            bus_read(8'(i), rd);
            check_eq($sformatf("dout at offset %0d", i), 32'(rd), 32'(v[7:0]));
        end
        apply_reset();
        check_eq("dout", 32'(dout), 0);
        check_eq("pwm pins", 32'({pwm1, pwm0}), 0);
        check_eq("flag pins", 32'({match1_flag, match0_flag, top_flag}), 0);
        for (int i = 0; i <= 6; i++) begin
            bus_read(8'(i), rd);
            check_eq($sformatf("dout at offset %0d after reset", i), 32'(rd), 0);
        end
    endtask

    task automatic ctc_test();
        logic [31:0] s;
        logic [31:0] c;
        logic [7:0]  rd;
        int          period;
        int          cycles;
        apply_reset();
        rand_bits(2, s);
        rand_bits(3, c);
        period = (int'(c) + 1) * (int'(s) + 1);
        bus_write(OFS_SCALE_LO, s[7:0]);
        bus_write(OFS_CMPR0, c[7:0]);
        bus_write(OFS_CONTROL, control_byte(MODE_CTC, 1'b0));
        measure_toggle(4 * period + 16, cycles);   // Align to the first toggle
        repeat (2) begin
            measure_toggle(4 * period + 16, cycles);
            check_eq("pwm0 toggle interval", cycles, period);
        end
        repeat (6) begin
            bus_read(OFS_COUNTER, rd);
            assert (rd <= c[7:0]) else begin
                mismatches++;
                $display("mismatch counter: got 0x%0h, above cmpr0 0x%0h", rd, c[7:0]);
            end
        end
    endtask

    task automatic pwm_test();
        logic [31:0] s;
        logic [31:0] c0;
        logic [31:0] c1;
        int          period;
        int          high0;
        int          high1;
        apply_reset();
        rand_bits(2, s);
        rand_bits(8, c0);
        rand_bits(8, c1);
        period = 256 * (int'(s) + 1);
        bus_write(OFS_SCALE_LO, s[7:0]);
        bus_write(OFS_CMPR0, c0[7:0]);
        bus_write(OFS_CMPR1, c1[7:0]);
        bus_write(OFS_CONTROL, control_byte(MODE_PWM, 1'b0));
        wait_pwm0(1'b1, 2 * period);   // First wrap past 255
        high0 = 0;
        high1 = 0;
        repeat (period) begin
            @(posedge clk);
            #1;
            high0 += int'(pwm0);
            high1 += int'(pwm1);
        end
        check_eq("pwm0 high clocks", high0, (int'(c0) + 1) * (int'(s) + 1));
        check_eq("pwm1 high clocks", high1, (int'(c1) + 1) * (int'(s) + 1));
    endtask

    // ******************************************************************
    // Interrupt flags
    // ******************************************************************
    task automatic irq_test();
        logic [31:0] s;
        logic [31:0] c0;
        logic [31:0] c1;
        logic [2:0]  prev;
        logic [2:0]  now_f;
        logic [7:0]  rd;
        int          rises [3];
        int          period;
        apply_reset();
        rand_bits(1, s);
        rand_bits(8, c0);
        rand_bits(8, c1);
        period = 256 * (int'(s) + 1);
        rises  = '{0, 0, 0};
        prev   = 3'b000;
        bus_write(OFS_SCALE_LO, s[7:0]);
        bus_write(OFS_CMPR0, c0[7:0]);
        bus_write(OFS_CMPR1, c1[7:0]);
        bus_write(OFS_CONTROL, control_byte(MODE_PWM, 1'b1));
        // Warm up for one period, then count over two
        for (int t = 0; t < 3 * period; t++) begin
            @(posedge clk);
            #1;
            now_f = {match1_flag, match0_flag, top_flag};
            top_flag_clr    = now_f[FLAG_TOP];
            match0_flag_clr = now_f[FLAG_M0];
            match1_flag_clr = now_f[FLAG_M1];
            for (int i = 0; i < 3; i++) begin
                if (t >= period && now_f[i] && !prev[i]) begin
                    rises[i]++;
                end
            end
            prev = now_f;
        end
        @(posedge clk);
        #1;
        {match1_flag_clr, match0_flag_clr, top_flag_clr} = 3'b000;
        for (int i = 0; i < 3; i++) begin
            check_eq($sformatf("rise count of flag %0d", i), rises[i], 2);
        end

        // Frozen counter, so no new events while the flags are written
        bus_write(OFS_CONTROL, control_byte(MODE_HOLD, 1'b1));
        repeat (4) @(posedge clk);
        bus_write(OFS_FLAGS, 8'h05);
        bus_read(OFS_FLAGS, rd);
        check_eq("flags readback", 32'(rd), 32'h05);
        check_eq("flag pins", 32'({match1_flag, match0_flag, top_flag}), 32'h5);
        bus_write(OFS_FLAGS, 8'h02);
        bus_read(OFS_FLAGS, rd);
        check_eq("flags readback", 32'(rd), 32'h02);

        bus_write(OFS_CONTROL, control_byte(MODE_PWM, 1'b0));
        bus_write(OFS_FLAGS, 8'h00);
        repeat (2 * period) begin
            @(posedge clk);
            #1;
            assert ({match1_flag, match0_flag, top_flag} == 3'b000) else begin
                failures++;
                $display("a flag went high with its interrupt enable off");
            end
        end
    endtask

    task automatic hold_idle_test();
        logic [31:0] s;
        logic [7:0]  held;
        logic [7:0]  rd;
        int          ticks;
        apply_reset();
        rand_bits(2, s);
        ticks = int'(s) + 1;
        bus_write(OFS_SCALE_LO, s[7:0]);
        bus_write(OFS_CMPR0, 8'hff);   // Outputs stay high once set
        bus_write(OFS_CMPR1, 8'hff);
        bus_write(OFS_CONTROL, control_byte(MODE_PWM, 1'b0));
        wait_pwm0(1'b1, 300 * ticks);
        repeat (4 * ticks) @(posedge clk);   // Let the count move off zero
        bus_write(OFS_CONTROL, control_byte(MODE_HOLD, 1'b0));
        bus_read(OFS_COUNTER, held);
        repeat (3) begin
            repeat (3 * ticks) @(posedge clk);
            bus_read(OFS_COUNTER, rd);
            check_eq("counter in hold", 32'(rd), 32'(held));
            check_eq("pwm pins in hold", 32'({pwm1, pwm0}), 32'h3);
        end
        bus_write(OFS_CONTROL, control_byte(MODE_IDLE, 1'b0));
        repeat (ticks) @(posedge clk);   // Next tick has landed
        #1;
        check_eq("pwm pins in idle", 32'({pwm1, pwm0}), 0);
        bus_read(OFS_COUNTER, rd);
        check_eq("counter in idle", 32'(rd), 0);
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        apply_reset();   // Also sets every input
        check_eq("dout", 32'(dout), 0);
        regs_test();
        ctc_test();
        pwm_test();
        irq_test();
        hold_idle_test();
        finish_run();
    end

    // Watchdog
    initial begin
        #2_000_000;
        failures++;
        $display("simulation did not finish within its time limit");
        finish_run();
    end

endmodule

// File: timer.f
timer_pkg.sv
timer_cfg_if.sv
timer_regs.sv
timer_prescaler.sv
timer_counter.sv
timer_irq.sv
timer_top.sv
tb_timer.sv

// File: Makefile
TOP := tb_timer

sim:
	verilator --binary --assert --timing -f timer.f --top-module $(TOP) -Mdir obj_dir -o sim_timer
	./obj_dir/sim_timer | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
